/* controlUnit_stimulus.txt */
# in: instr aluFlags flushE stallE stallM stallW done mCycleResult
# out: immSrc regSrc mStartD aluCtl aluSrc mCycOp pcSrc rwE m2rE mStart mWrite memW rwM rw m2r
E2821005 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E5915004 0 0 0 0 0 0 0 1 0 0 0 1 0 0 1 0 0 0 0 0 0 0
E5815004 0 0 0 0 0 0 0 1 2 0 0 1 0 0 1 1 0 0 0 1 0 0
EA000002 0 0 0 0 0 0 0 2 1 0 0 1 0 0 0 0 0 0 0 1 1 0
E3510005 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 0 0 0 1 0 1 1
00413002 4 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0
11914002 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 0 0 0 0 0 0 0
E28FF008 B 0 0 0 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 1 0 0
E3510005 0 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0 0 1 0
E1914002 3 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 1 0 0
00413002 4 0 0 0 0 0 0 0 0 0 3 0 0 0 1 0 0 0 0 0 1 0
22821005 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 0 0 0 0 1 0 0
1A000002 0 0 0 0 0 0 0 2 1 0 0 1 0 0 1 0 0 0 0 1 1 0
E0020391 0 0 0 0 0 0 0 0 4 1 0 1 0 0 0 0 0 0 0 1 1 0
E0220391 0 0 0 0 0 1 0 0 4 0 0 0 0 0 0 0 1 1 0 0 1 0
10020391 0 0 0 0 0 0 0 0 4 1 0 0 1 0 0 0 0 1 0 0 0 0
E2821005 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
E5815004 0 0 1 0 0 0 0 1 2 0 0 1 0 0 1 0 0 0 0 1 0 0
E5815004 0 1 0 0 0 0 0 1 2 0 0 1 0 0 1 0 0 0 0 1 1 0
E5915004 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 0
E5815004 0 0 0 0 0 0 0 1 2 0 0 1 0 0 1 1 0 0 0 0 1 0
EA000002 0 0 0 1 0 0 0 2 1 0 0 1 0 0 0 0 0 0 0 1 0 0
E2821005 0 0 0 0 1 0 0 0 0 0 0 1 0 1 0 0 0 0 0 1 1 1
E2821005 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0 0 1 1
E5815004 0 0 0 0 0 0 0 1 2 0 0 1 0 0 1 0 0 0 0 1 0 0
E0000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 1 0
E0000000 0 0 0 0 0 0 0 0 0 0 2 0 0 0 1 0 0 0 1 0 1 0

/* armctl.f */
+incdir+.
armctl_pkg.sv
instrDecoder.sv
condLogic.sv
decodeExecuteReg.sv
lateStageRegs.sv
controlUnit.sv
controlUnit_asserts.sv
controlUnit_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f armctl.f \
    --top-module controlUnit_tb -o simv \
    && ./obj_dir/simv \
    || exit 1

/* controlUnit_tb.sv */
`timescale 1ns/1ps

module controlUnit_tb;

    logic                CLK;
    logic                arstN;
    armctl_pkg::instrT   instr;
    armctl_pkg::flagsT   aluFlags;
    logic                flushE;
    logic                stallE;
    logic                stallM;
    logic                stallW;
    logic                done;
    logic                mCycleResult;

    logic                memtoReg;
    logic                memWrite;
    logic                aluSrc;
    armctl_pkg::immSrcT  immSrc;
    logic                regWrite;
    armctl_pkg::regSrcT  regSrc;
    armctl_pkg::aluCtrlT aluControl;
    logic                pcSrc;
    logic                mStart;
    logic                mCycleOp;
    logic                mWrite;
    logic                regWriteM;
    logic                regWriteE;
    logic                memtoRegE;
    logic                mStartD;

    controlUnit uut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // flushE high while idle so E starts out as a bubble
    initial begin
        arstN        = 1'b0;
        instr        = '0;
        aluFlags     = '0;
        flushE       = 1'b1;
        stallE       = 1'b0;
        stallM       = 1'b0;
        stallW       = 1'b0;
        done         = 1'b0;
        mCycleResult = 1'b0;
        repeat (8) @(posedge CLK);
        #2 arstN = 1'b1;
    end

    // run-length limit
    initial begin
        for (int i = 0; i < 200; i++) begin
            @(posedge CLK);
        end
        $display(">>> FAIL");
        $fatal(1, "simulation ran past its cycle limit");
    end

    task automatic compareOut(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    initial begin
        int          fd;
        int          cnt;
        int          waitCycles;
        int          rows;
        string       line;
        logic [31:0] v [23];

        rows = 0;
        fd = $fopen("controlUnit_stimulus.txt", "r");
        if (fd == 0) begin
            $display(">>> FAIL");
            $fatal(1, "could not open the stimulus file");
        end

        waitCycles = 0;
        while (!arstN) begin
            if (waitCycles > 20) begin
                $display(">>> FAIL");
                $fatal(1, "reset was never released");
            end
            @(negedge CLK);
            waitCycles++;
        end

        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                          v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                          v[20], v[21], v[22]);
            if (cnt != 23) begin
                $display(">>> FAIL");
                $fatal(1, "malformed line in the stimulus file");
            end
            @(posedge CLK);
            #2;
            instr        = v[0];
            aluFlags     = v[1][3:0];
            flushE       = v[2][0];
            stallE       = v[3][0];
            stallM       = v[4][0];
            stallW       = v[5][0];
            done         = v[6][0];
            mCycleResult = v[7][0];
            #16;   // just before the next edge
            compareOut("immSrc", v[8], 32'(immSrc));
            compareOut("regSrc", v[9], 32'(regSrc));
            compareOut("mStartD", v[10], 32'(mStartD));
            compareOut("aluControl", v[11], 32'(aluControl));
            compareOut("aluSrc", v[12], 32'(aluSrc));
            compareOut("mCycleOp", v[13], 32'(mCycleOp));
            compareOut("pcSrc", v[14], 32'(pcSrc));
            compareOut("regWriteE", v[15], 32'(regWriteE));
            compareOut("memtoRegE", v[16], 32'(memtoRegE));
            compareOut("mStart", v[17], 32'(mStart));
            compareOut("mWrite", v[18], 32'(mWrite));
            compareOut("memWrite", v[19], 32'(memWrite));
            compareOut("regWriteM", v[20], 32'(regWriteM));
            compareOut("regWrite", v[21], 32'(regWrite));
            compareOut("memtoReg", v[22], 32'(memtoReg));
            rows++;
        end
        $fclose(fd);

        if (rows == 0) begin
            $display(">>> FAIL");
            $fatal(1, "stimulus file held no vectors");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* controlUnit_asserts.sv */
`timescale 1ns/1ps

module controlUnit_asserts (
    input logic       CLK,
    input logic       arstN,
    input logic       stall,
    input logic [4:0] hold,
    input logic [4:0] writes,
    input logic       condOk,
    input logic       regWrite
);

    // nothing fires straight out of reset
    assert property (@(posedge CLK) $rose(arstN) |-> (writes == '0))
        else $error("write output active in first cycle after reset");

    assert property (@(posedge CLK) disable iff (!arstN) stall |=> $stable(hold))
        else $error("held register moved while stalled");

    assert property (@(posedge CLK) disable iff (!arstN) !condOk |-> !regWrite)
        else $error("regWrite raised with failing condition");

endmodule

bind condLogic controlUnit_asserts uCondChk (
    .CLK(CLK), .arstN(arstN), .stall(stall), .hold({1'b0, flags}),
    .writes({pcSrc, regWrite, memWrite, mStart, mWrite}),
    .condOk(!((ctrl.cond == 4'b0000 && !flags[2]) || (ctrl.cond == 4'b0001 && flags[2]))),
    .regWrite(regWrite)
);

bind lateStageRegs controlUnit_asserts uLateChk (
    .CLK(CLK), .arstN(arstN), .stall(stallM), .hold(m),
    .writes({m.pcSrc, m.regWrite, m.memWrite, w.pcSrc, w.regWrite}),
    .condOk(1'b1), .regWrite(1'b0)
);

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  armctl_pkg::instrT   instr,
    input  armctl_pkg::flagsT   aluFlags,
    input  logic                CLK,
    input  logic                arstN,
    input  logic                flushE,
    input  logic                stallE,
    input  logic                stallM,
    input  logic                stallW,
    input  logic                done,
    input  logic                mCycleResult,
    output logic                memtoReg,
    output logic                memWrite,
    output logic                aluSrc,
    output armctl_pkg::immSrcT  immSrc,
    output logic                regWrite,
    output armctl_pkg::regSrcT  regSrc,
    output armctl_pkg::aluCtrlT aluControl,
    output logic                pcSrc,
    output logic                mStart,
    output logic                mCycleOp,
    output logic                mWrite,
    output logic                regWriteM,
    output logic                regWriteE,
    output logic                memtoRegE,
    output logic                mStartD
);

    armctl_pkg::ctrlDT ctrlD;
    armctl_pkg::ctrlDT ctrlE;
    armctl_pkg::ctrlMT ctrlEOut;
    armctl_pkg::ctrlMT ctrlM;
    armctl_pkg::ctrlWT ctrlW;

    logic pcSrcE;
    logic regWriteCond;
    logic memWriteCond;
    logic mWriteE;

    instrDecoder uDecoder (
        .instr  (instr),
        .done   (done),
        .ctrl   (ctrlD),
        .immSrc (immSrc),
        .regSrc (regSrc)
    );

    decodeExecuteReg uDecExReg (
        .CLK   (CLK),
        .arstN (arstN),
        .stall (stallE),
        .flush (flushE),
        .d     (ctrlD),
        .e     (ctrlE)
    );

    condLogic uCondLogic (
        .CLK      (CLK),
        .arstN    (arstN),
        .stall    (stallE),
        .ctrl     (ctrlE),
        .aluFlags (aluFlags),
        .pcSrc    (pcSrcE),
        .regWrite (regWriteCond),
        .memWrite (memWriteCond),
        .mStart   (mStart),
        .mWrite   (mWriteE)
    );

    // multi-cycle result takes over the E write port
    always_comb begin
        ctrlEOut.pcSrc    = pcSrcE;
        ctrlEOut.regWrite = mCycleResult ? 1'b1 : regWriteCond;
        ctrlEOut.memWrite = mCycleResult ? 1'b0 : memWriteCond;
        ctrlEOut.memtoReg = mCycleResult ? 1'b0 : ctrlE.memtoReg;
        ctrlEOut.mWrite   = mWriteE;
    end

    lateStageRegs uLateRegs (
        .CLK    (CLK),
        .arstN  (arstN),
        .stallM (stallM),
        .stallW (stallW),
        .e      (ctrlEOut),
        .m      (ctrlM),
        .w      (ctrlW)
    );

    assign mStartD    = ctrlD.mStart;
    assign aluSrc     = ctrlE.aluSrc;
    assign aluControl = ctrlE.aluControl;
    assign mCycleOp   = ctrlE.mCycleOp;
    assign pcSrc      = pcSrcE;
    assign mWrite     = mWriteE;
    assign regWriteE  = ctrlEOut.regWrite;
    assign memtoRegE  = ctrlEOut.memtoReg;
    assign memWrite   = ctrlM.memWrite;
    assign regWriteM  = ctrlM.regWrite;
    assign regWrite   = ctrlW.regWrite;
    assign memtoReg   = ctrlW.memtoReg;

endmodule

/* lateStageRegs.sv */
`timescale 1ns/1ps

module lateStageRegs (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              stallM,
    input  logic              stallW,
    input  armctl_pkg::ctrlMT e,
    output armctl_pkg::ctrlMT m,
    output armctl_pkg::ctrlWT w
);

    armctl_pkg::ctrlWT wNext;

    // memWrite is consumed in M, not carried on
    always_comb begin
        wNext.pcSrc    = m.pcSrc;
        wNext.regWrite = m.regWrite;
        wNext.memtoReg = m.memtoReg;
        wNext.mWrite   = m.mWrite;
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            m <= '0;
        end else if (!stallM) begin
            m <= e;
        end
    end

    // W advances even if M holds
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            w <= '0;
        end else if (!stallW) begin
            w <= wNext;
        end
    end

endmodule

/* decodeExecuteReg.sv */
`timescale 1ns/1ps

module decodeExecuteReg (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              stall,
    input  logic              flush,
    input  armctl_pkg::ctrlDT d,
    output armctl_pkg::ctrlDT e
);

    // all-zero word, no writes, no start, no branch
    localparam armctl_pkg::ctrlDT Bubble = '0;

    armctl_pkg::ctrlDT eNext;

    // stall beats flush
    always_comb begin
        if (stall) begin
            eNext = e;
        end else if (flush) begin
            eNext = Bubble;
        end else begin
            eNext = d;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            e <= Bubble;
        end else begin
            e <= eNext;
        end
    end

endmodule

/* condLogic.sv */
`timescale 1ns/1ps

module condLogic (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              stall,
    input  armctl_pkg::ctrlDT ctrl,
    input  armctl_pkg::flagsT aluFlags,
    output logic              pcSrc,
    output logic              regWrite,
    output logic              memWrite,
    output logic              mStart,
    output logic              mWrite
);

    armctl_pkg::flagsT flags;
    logic n;
    logic z;
    logic c;
    logic v;
    logic condEx;

    assign {n, z, c, v} = flags;

    always_comb begin
        case (ctrl.cond)
            4'b0000: condEx = z;                      // EQ
            4'b0001: condEx = ~z;                     // NE
            4'b0010: condEx = c;                      // CS
            4'b0011: condEx = ~c;                     // CC
            4'b0100: condEx = n;                      // MI
            4'b0101: condEx = ~n;                     // PL
            4'b0110: condEx = v;                      // VS
            4'b0111: condEx = ~v;                     // VC
            4'b1000: condEx = c & ~z;                 // HI
            4'b1001: condEx = ~c | z;                 // LS
            4'b1010: condEx = (n == v);               // GE
            4'b1011: condEx = (n != v);               // LT
            4'b1100: condEx = ~z & (n == v);          // GT
            4'b1101: condEx = z | (n != v);           // LE
            4'b1110: condEx = 1'b1;                   // AL
            default: condEx = 1'b0;
        endcase
    end

    // flag halves update independently
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (!stall) begin
            if (ctrl.flagW[1] && condEx) begin
                flags[3:2] <= aluFlags[3:2];
            end
            if (ctrl.flagW[0] && condEx) begin
                flags[1:0] <= aluFlags[1:0];
            end
        end
    end

    assign pcSrc    = ctrl.pcs & condEx;
    assign regWrite = ctrl.regW & ~ctrl.noWrite & condEx;   // CMP/CMN never write
    assign memWrite = ctrl.memW & condEx;
    assign mStart   = ctrl.mStart & condEx;
    assign mWrite   = ctrl.mWrite & condEx;

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps
`include "armctl_cfg.svh"

module instrDecoder (
    input  armctl_pkg::instrT  instr,
    input  logic               done,
    output armctl_pkg::ctrlDT  ctrl,
    output armctl_pkg::immSrcT immSrc,
    output armctl_pkg::regSrcT regSrc
);

    logic [1:0] op;
    logic [3:0] cmd;
    logic [3:0] rd;
    logic       iBit;
    logic       sBit;
    logic       lBit;
    logic       uBit;
    logic       isMcyc;
    logic       isLogic;

    assign op   = instr[`OP_HI -: 2];
    assign cmd  = instr[`CMD_HI -: 4];
    assign rd   = instr[`RD_HI -: 4];
    assign iBit = instr[`I_BIT];
    assign sBit = instr[`S_BIT];
    assign lBit = instr[`L_BIT];
    assign uBit = instr[`U_BIT];

    // MUL/DIV sit in the DP space with bits 25:22 clear and the 1001 signature
    assign isMcyc = (op == `OP_DP) && (instr[`I_BIT -: 4] == 4'b0000)
                    && (instr[`SIG_HI -: 4] == `MCYC_SIG);

    assign isLogic = (cmd == `CMD_AND) || (cmd == `CMD_ORR);

    always_comb begin
        ctrl      = '0;
        ctrl.cond = instr[`COND_HI -: 4];
        immSrc    = `IMM_DP;
        regSrc    = 3'b000;

        case (op)
            `OP_DP: begin
                if (isMcyc) begin
                    ctrl.mStart   = ~done;   // no new start while a result is out
                    ctrl.mCycleOp = instr[`MCYC_OP_BIT];
                    ctrl.mWrite   = 1'b1;
                    regSrc        = 3'b100;
                end else begin
                    ctrl.regW   = 1'b1;
                    ctrl.aluSrc = iBit;
                    case (cmd)
                        `CMD_ADD: ctrl.aluControl = `ALU_ADD;
                        `CMD_SUB: ctrl.aluControl = `ALU_SUB;
                        `CMD_AND: ctrl.aluControl = `ALU_AND;
                        `CMD_ORR: ctrl.aluControl = `ALU_ORR;
                        `CMD_CMP: begin
                            ctrl.aluControl = `ALU_SUB;
                            ctrl.noWrite    = 1'b1;
                        end
                        `CMD_CMN: begin
                            ctrl.aluControl = `ALU_ADD;
                            ctrl.noWrite    = 1'b1;
                        end
                        default: ctrl.regW = 1'b0;   // outside the subset
                    endcase
                    // logical ops leave C and V alone
                    if (sBit && ctrl.regW) begin
                        ctrl.flagW = isLogic ? 2'b10 : 2'b11;
                    end
                end
            end
            `OP_MEM: begin
                ctrl.regW       = lBit;
                ctrl.memW       = ~lBit;
                ctrl.memtoReg   = lBit;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = uBit ? `ALU_ADD : `ALU_SUB;  // offset direction
                immSrc          = `IMM_MEM;
                regSrc          = {1'b0, ~lBit, 1'b0};   // STR reads Rd
            end
            `OP_BR: begin
                ctrl.pcs    = 1'b1;
                ctrl.aluSrc = 1'b1;
                immSrc      = `IMM_BR;
                regSrc      = 3'b001;
            end
            default: ctrl.regW = 1'b0;
        endcase

        // a real write to R15 redirects the PC
        if (ctrl.regW && !ctrl.noWrite && (rd == 4'd15)) begin
            ctrl.pcs = 1'b1;
        end
    end

endmodule

/* armctl_pkg.sv */
package armctl_pkg;

    typedef logic [31:0] instrT;
    typedef logic [3:0]  condT;
    typedef logic [3:0]  flagsT;    // N Z C V, N in bit 3
    typedef logic [1:0]  aluCtrlT;
    typedef logic [1:0]  immSrcT;
    typedef logic [2:0]  regSrcT;   // [0] branch pc, [1] store Rd, [2] mul order
    typedef logic [1:0]  flagWT;    // [1] NZ, [0] CV

    // decoded controls, carried D -> E
    typedef struct packed {
        logic    pcs;
        logic    regW;
        logic    memW;
        logic    memtoReg;
        logic    aluSrc;
        logic    noWrite;
        logic    mStart;
        logic    mCycleOp;   // 0 mul, 1 div
        logic    mWrite;
        flagWT   flagW;
        aluCtrlT aluControl;
        condT    cond;
    } ctrlDT;

    // gated controls leaving E
    typedef struct packed {
        logic pcSrc;
        logic regWrite;
        logic memWrite;
        logic memtoReg;
        logic mWrite;
    } ctrlMT;

    typedef struct packed {
        logic pcSrc;
        logic regWrite;
        logic memtoReg;
        logic mWrite;
    } ctrlWT;

endpackage

/* armctl_cfg.svh */
`ifndef ARMCTL_CFG_SVH
`define ARMCTL_CFG_SVH

// instruction field positions
`define COND_HI      31
`define OP_HI        27
`define I_BIT        25
`define CMD_HI       24
`define U_BIT        23
`define MCYC_OP_BIT  21
`define S_BIT        20
`define L_BIT        20
`define RD_HI        15
`define SIG_HI       7

// op field
`define OP_DP        2'b00
`define OP_MEM       2'b01
`define OP_BR        2'b10

// data-processing cmd field
`define CMD_AND      4'b0000
`define CMD_SUB      4'b0010
`define CMD_ADD      4'b0100
`define CMD_CMP      4'b1010
`define CMD_CMN      4'b1011
`define CMD_ORR      4'b1100

`define MCYC_SIG     4'b1001  // bits 7:4 of MUL/DIV

`define ALU_ADD      2'b00
`define ALU_SUB      2'b01
`define ALU_AND      2'b10
`define ALU_ORR      2'b11

`define IMM_DP       2'b00
`define IMM_MEM      2'b01
`define IMM_BR       2'b10

`endif
